// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] instr_t;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Operation classes as seen by the sequencer.
    typedef enum logic [2:0] {
        OP_ALU,
        OP_MUL,
        OP_DIV,
        OP_LUI,
        OP_ILLEGAL
    } exec_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_DIV,
        ST_WB
    } exec_state_e;

    // One quotient bit is produced per divider iteration.
    localparam int DIV_STEPS = 32;

endpackage

`default_nettype wire

// File: rtl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  instr_t     instr,
    output exec_op_e   op,
    output reg_idx_t   rs1_idx,
    output reg_idx_t   rs2_idx,
    output reg_idx_t   rd_idx,
    output logic [2:0] funct3,
    output logic       alt,
    output logic       use_imm,
    output xlen_t      imm
);

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       is_shift_right;
    logic       base_funct7_ok;

    assign opcode  = instr[6:0];
    assign funct7  = instr[31:25];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];
    assign funct3  = instr[14:12];

    assign is_shift_right = (funct3 == 3'b101);

    // Only add/sub and the right shifts have an alternate funct7 encoding.
    assign base_funct7_ok = (funct7 == 7'b0) ||
                            (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || is_shift_right));

    // Immediate forms never subtract, so alt only survives for SRAI there.
    assign alt     = instr[30] && (opcode == OPC_OP || is_shift_right);
    assign use_imm = (opcode == OPC_OP_IMM);

    assign imm = (opcode == OPC_LUI) ? {instr[31:12], 12'h000}
                                     : {{20{instr[31]}}, instr[31:20]};

    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            OPC_LUI: op = OP_LUI;
            OPC_OP: begin
                if (funct7 == FUNCT7_MULDIV) begin
                    op = funct3[2] ? OP_DIV : OP_MUL;
                end else if (base_funct7_ok) begin
                    op = OP_ALU;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    op = (funct7 == 7'b0) ? OP_ALU : OP_ILLEGAL;
                end else if (is_shift_right) begin
                    op = base_funct7_ok ? OP_ALU : OP_ILLEGAL;
                end else begin
                    op = OP_ALU;
                end
            end
            default: op = OP_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  xlen_t      a,
    input  xlen_t      b,
    input  logic [2:0] funct3,
    input  logic       alt,
    input  logic       muldiv,
    output xlen_t      y
);

    logic [32:0] minus;
    xlen_t       sum;
    logic        lt_u;
    logic        lt_s;
    logic [4:0]  shamt;
    xlen_t       shl;
    xlen_t       shr;
    xlen_t       base_y;

    logic        a_neg;
    logic        b_neg;
    xlen_t       a_mag;
    xlen_t       b_mag;
    dword_t      prod_mag;
    dword_t      prod;

    assign sum   = a + b;
    assign minus = {1'b0, a} - {1'b0, b};
    assign lt_u  = minus[32];
    // Different signs decide the signed compare on their own.
    assign lt_s  = (a[31] ^ b[31]) ? a[31] : lt_u;

    assign shamt = b[4:0];
    assign shl   = a << shamt;
    assign shr   = alt ? xlen_t'($signed(a) >>> shamt) : (a >> shamt);

    always_comb begin
        case (funct3)
            3'b000:  base_y = alt ? minus[31:0] : sum;
            3'b001:  base_y = shl;
            3'b010:  base_y = {31'h0, lt_s};
            3'b011:  base_y = {31'h0, lt_u};
            3'b100:  base_y = a ^ b;
            3'b101:  base_y = shr;
            3'b110:  base_y = a | b;
            default: base_y = a & b;
        endcase
    end

    // mulh treats both operands as signed, mulhsu only the first, mulhu neither.
    // The low word of mul is the same either way.
    assign a_neg = (funct3 == 3'b001 || funct3 == 3'b010) && a[31];
    assign b_neg = (funct3 == 3'b001) && b[31];

    assign a_mag    = a_neg ? -a : a;
    assign b_mag    = b_neg ? -b : b;
    assign prod_mag = dword_t'(a_mag) * dword_t'(b_mag);
    assign prod     = (a_neg ^ b_neg) ? -prod_mag : prod_mag;

    always_comb begin
        if (muldiv) begin
            y = (funct3 == 3'b000) ? prod[31:0] : prod[63:32];
        end else begin
            y = base_y;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_divider.sv
`timescale 1ns/1ps
`default_nettype none

module rv_divider import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  xlen_t      dividend,
    input  xlen_t      divisor,
    input  logic [2:0] funct3,
    output logic       done,
    output xlen_t      result
);

    localparam int CNT_W = $clog2(DIV_STEPS);

    logic              running;
    logic [CNT_W-1:0]  count;
    xlen_t             quo;
    xlen_t             rem;
    xlen_t             dvs;
    logic              neg_quo;
    logic              neg_rem;
    logic              want_rem;
    logic              is_signed;
    xlen_t             mag_dividend;
    xlen_t             mag_divisor;
    logic [32:0]       shifted;
    logic [32:0]       trial;

    assign is_signed    = !funct3[0];
    assign mag_dividend = (is_signed && dividend[31]) ? -dividend : dividend;
    assign mag_divisor  = (is_signed && divisor[31]) ? -divisor : divisor;

    // Partial remainder with the next dividend bit shifted in. A borrow means
    // the divisor did not fit and the remainder is restored.
    assign shifted = {rem, quo[31]};
    assign trial   = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (count == CNT_W'(DIV_STEPS - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo      <= mag_dividend;
            rem      <= '0;
            dvs      <= mag_divisor;
            neg_quo  <= is_signed && (dividend[31] ^ divisor[31]);
            neg_rem  <= is_signed && dividend[31];
            want_rem <= funct3[1];
        end else if (running) begin
            if (!trial[32]) begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= shifted[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    // The remainder takes the sign of the dividend.
    assign result = want_rem ? (neg_rem ? -rem : rem)
                             : (neg_quo ? -quo : quo);

endmodule

`default_nettype wire

// File: rtl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  exec_op_e   op,
    input  reg_idx_t   rd_idx,
    input  logic [2:0] funct3,
    input  logic       alt,
    input  logic       use_imm,
    input  xlen_t      imm,
    input  xlen_t      rs1_val,
    input  xlen_t      rs2_val,
    output logic       busy,
    output logic       illegal,
    output logic       wr_en,
    output reg_idx_t   wr_rd,
    output xlen_t      wr_data
);

    exec_state_e state;
    logic        accept;
    logic        in_mul;
    xlen_t       op_a_q;
    xlen_t       op_b_q;
    logic [2:0]  funct3_q;
    xlen_t       alu_a;
    xlen_t       alu_b;
    logic [2:0]  alu_funct3;
    xlen_t       alu_y;
    logic        div_start;
    logic        div_done;
    xlen_t       div_result;

    assign busy      = (state == ST_MUL) || (state == ST_DIV);
    assign wr_en     = (state == ST_WB);
    assign accept    = instr_valid && !busy;
    assign in_mul    = (state == ST_MUL);
    assign div_start = accept && (op == OP_DIV);

    // Plain ALU ops work on the live operands at issue; the multiplier
    // works on the copy captured at issue during its wait cycle.
    assign alu_a      = in_mul ? op_a_q : rs1_val;
    assign alu_b      = in_mul ? op_b_q : (use_imm ? imm : rs2_val);
    assign alu_funct3 = in_mul ? funct3_q : funct3;

    rv_alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .funct3 (alu_funct3),
        .alt    (alt),
        .muldiv (in_mul),
        .y      (alu_y)
    );

    rv_divider divider_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (rs1_val),
        .divisor  (rs2_val),
        .funct3   (funct3),
        .done     (div_done),
        .result   (div_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            illegal <= 1'b0;
        end else begin
            illegal <= accept && (op == OP_ILLEGAL);
            case (state)
                ST_MUL: state <= ST_WB;
                ST_DIV: begin
                    if (div_done) begin
                        state <= ST_WB;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    if (accept) begin
                        case (op)
                            OP_ALU, OP_LUI: state <= ST_WB;
                            OP_MUL:         state <= ST_MUL;
                            OP_DIV:         state <= ST_DIV;
                            default:        state <= ST_IDLE;
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_rd    <= rd_idx;
            op_a_q   <= rs1_val;
            op_b_q   <= rs2_val;
            funct3_q <= funct3;
        end
        if (accept && op == OP_ALU) begin
            wr_data <= alu_y;
        end else if (accept && op == OP_LUI) begin
            wr_data <= imm;
        end else if (in_mul) begin
            wr_data <= alu_y;
        end else if (state == ST_DIV && div_done) begin
            wr_data <= div_result;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output xlen_t    rs1_val,
    output xlen_t    rs2_val,
    input  logic     wr_en,
    input  reg_idx_t wr_rd,
    input  xlen_t    wr_data,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output xlen_t    wb_data
);

    xlen_t regs [NUM_REGS];

    // x0 is never written, and indices past the file read as zero.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_rd != '0 && int'(wr_rd) < NUM_REGS) begin
            regs[wr_rd] <= wr_data;
        end
    end

    assign rs1_val = (rs1_idx == '0 || int'(rs1_idx) >= NUM_REGS) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0 || int'(rs2_idx) >= NUM_REGS) ? '0 : regs[rs2_idx];

    // Every write is reported, including those aimed at x0.
    assign wb_valid = wr_en;
    assign wb_rd    = wr_rd;
    assign wb_data  = wr_data;

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,
    input  instr_t   instr,
    output logic     busy,
    output logic     wb_valid,
    output logic     illegal,
    output reg_idx_t wb_rd,
    output xlen_t    wb_data
);

    exec_op_e   op;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    reg_idx_t   rd_idx;
    logic [2:0] funct3;
    logic       alt;
    logic       use_imm;
    xlen_t      imm;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    logic       wr_en;
    reg_idx_t   wr_rd;
    xlen_t      wr_data;

    rv_decode decode_i (
        .instr   (instr),
        .op      (op),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rd_idx  (rd_idx),
        .funct3  (funct3),
        .alt     (alt),
        .use_imm (use_imm),
        .imm     (imm)
    );

    rv_execute execute_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .op          (op),
        .rd_idx      (rd_idx),
        .funct3      (funct3),
        .alt         (alt),
        .use_imm     (use_imm),
        .imm         (imm),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .busy        (busy),
        .illegal     (illegal),
        .wr_en       (wr_en),
        .wr_rd       (wr_rd),
        .wr_data     (wr_data)
    );

    rv_result #(
        .NUM_REGS (NUM_REGS)
    ) result_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wr_en    (wr_en),
        .wr_rd    (wr_rd),
        .wr_data  (wr_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, like every other DUT input.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties import rv_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     instr_valid,
    input logic     busy,
    input logic     wb_valid,
    input logic     illegal,
    input exec_op_e op
);

    int   failures = 0;
    int   outstanding;
    logic accept;

    assign accept = instr_valid && !busy;

    // Accepted issues that still owe a writeback.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(accept && op != OP_ILLEGAL) - int'(wb_valid);
        end
    end

    alu_wb_next_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        accept && (op == OP_ALU || op == OP_LUI) |=> wb_valid && !busy)
    else begin
        failures++;
        $error("ALU or LUI writeback did not follow one cycle after issue");
    end

    mul_wb_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
        accept && op == OP_MUL |=> (busy && !wb_valid) ##1 (wb_valid && !busy))
    else begin
        failures++;
        $error("multiply writeback did not follow two cycles after issue");
    end

    // The divider holds busy for DIV_STEPS + 1 cycles before its writeback.
    div_wb_timing: assert property (@(posedge clk) disable iff (!rst_n)
        accept && op == OP_DIV |=> (busy && !wb_valid) [*DIV_STEPS + 1] ##1 (wb_valid && !busy))
    else begin
        failures++;
        $error("divide writeback timing or busy level is wrong");
    end

    illegal_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        accept && op == OP_ILLEGAL |=> illegal && !wb_valid)
    else begin
        failures++;
        $error("unsupported opcode did not raise illegal alone");
    end

    wb_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> outstanding > 0)
    else begin
        failures++;
        $error("writeback without an accepted issue");
    end

    illegal_excludes_wb: assert property (@(posedge clk) disable iff (!rst_n)
        !(illegal && wb_valid))
    else begin
        failures++;
        $error("illegal and wb_valid high together");
    end

endmodule

`default_nettype wire

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*;;

    localparam int ROUNDS     = 4;
    // Issues that finish within a few cycles over the whole run.
    localparam int ALU_TESTS  = 1 + ROUNDS * 28 + ROUNDS * 8 + ROUNDS * 4 + 3 + 3;
    localparam int DIV_TESTS  = ROUNDS * 4;
    localparam int MAX_CYCLES = 4 * ALU_TESTS + (DIV_STEPS + 6) * DIV_TESTS + 50;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    instr_t   instr;
    logic     busy;
    logic     wb_valid;
    logic     illegal;
    reg_idx_t wb_rd;
    xlen_t    wb_data;

    xlen_t    model_regs [32];
    reg_idx_t exp_rd_q [$];
    xlen_t    exp_data_q [$];
    reg_idx_t chk_rd;
    xlen_t    chk_data;
    int       seed;
    int       pass_count = 0;
    int       fail_count = 0;
    int       cycles = 0;

    tb_clk_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (2)
    ) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_core #(
        .NUM_REGS (32)
    ) rv_core_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .wb_valid    (wb_valid),
        .illegal     (illegal),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    bind rv_core rv_core_properties props_i (.*);

    function automatic instr_t r_type_word(input logic [6:0] f7, input reg_idx_t rs2,
                                           input reg_idx_t rs1, input logic [2:0] f3,
                                           input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type_word(input logic [11:0] imm12, input reg_idx_t rs1,
                                           input logic [2:0] f3, input reg_idx_t rd);
        return {imm12, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                        input xlen_t a, input xlen_t b);
        xlen_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Extending to 64 bits and multiplying modulo 2**64 gives the exact product.
    function automatic xlen_t mul_model(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        dword_t ea;
        dword_t eb;
        dword_t p;
        ea = (f3 == 3'b011) ? {32'h0, a} : {{32{a[31]}}, a};
        eb = (f3 == 3'b001) ? {{32{b[31]}}, b} : {32'h0, b};
        p  = ea * eb;
        return (f3 == 3'b000) ? p[31:0] : p[63:32];
    endfunction

    function automatic xlen_t div_model(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        xlen_t r;
        case (f3)
            3'b100:  r = $signed(a) / $signed(b);
            3'b101:  r = a / b;
            3'b110:  r = $signed(a) % $signed(b);
            default: r = a % b;
        endcase
        return r;
    endfunction

    task automatic issue(input instr_t ins);
        while (busy) @(negedge clk);
        instr       = ins;
        instr_valid = 1'b1;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // Offers a stray ADD to x31 while the core is busy. The core must drop it.
    task automatic poke_while_busy();
        for (int k = 0; k < 3; k++) begin
            if (busy) begin
                instr       = r_type_word(7'b0, 5'd2, 5'd1, 3'b000, 5'd31);
                instr_valid = 1'b1;
            end
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic exec_check(input instr_t ins, input reg_idx_t rd, input xlen_t expected,
                              input bit poke);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(expected);
        if (rd != '0) begin
            model_regs[rd] = expected;
        end
        issue(ins);
        if (poke) begin
            poke_while_busy();
        end
        while (!wb_valid) @(negedge clk);
        // There is no forwarding, so the next issue waits for the write edge.
        @(negedge clk);
    endtask

    task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input reg_idx_t rd,
                          input reg_idx_t rs1, input reg_idx_t rs2);
        xlen_t a;
        xlen_t b;
        xlen_t expected;
        a = model_regs[rs1];
        b = model_regs[rs2];
        if (f7 == FUNCT7_MULDIV) begin
            expected = f3[2] ? div_model(f3, a, b) : mul_model(f3, a, b);
        end else begin
            expected = alu_model(f3, f7[5], a, b);
        end
        exec_check(r_type_word(f7, rs2, rs1, f3, rd), rd, expected,
                   f7 == FUNCT7_MULDIV && f3[2]);
    endtask

    task automatic imm_op(input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rs1,
                          input logic [11:0] imm12);
        xlen_t b;
        logic  sra;
        b   = {{20{imm12[11]}}, imm12};
        sra = (f3 == 3'b101) && imm12[10];
        exec_check(i_type_word(imm12, rs1, f3, rd), rd,
                   alu_model(f3, sra, model_regs[rs1], b), 1'b0);
    endtask

    task automatic lui_op(input reg_idx_t rd, input logic [19:0] imm20);
        exec_check({imm20, rd, OPC_LUI}, rd, {imm20, 12'h000}, 1'b0);
    endtask

    // ADDI sign-extends its immediate, so the upper part absorbs bit 11.
    task automatic load_reg(input reg_idx_t rd, input xlen_t value);
        lui_op(rd, value[31:12] + 20'(value[11]));
        imm_op(3'b000, rd, rd, value[11:0]);
    endtask

    // Independent ALU ops issued on consecutive cycles into x20 to x23.
    task automatic alu_burst();
        logic [2:0] f3;
        logic       alt;
        xlen_t      expected;
        for (int k = 0; k < 4; k++) begin
            f3       = 3'(2 * k + 1);
            alt      = (k == 2);
            expected = alu_model(f3, alt, model_regs[1], model_regs[2]);
            exp_rd_q.push_back(reg_idx_t'(20 + k));
            exp_data_q.push_back(expected);
            model_regs[20 + k] = expected;
            instr       = r_type_word(alt ? 7'b0100000 : 7'b0, 5'd2, 5'd1, f3,
                                      reg_idx_t'(20 + k));
            instr_valid = 1'b1;
            @(negedge clk);
        end
        instr_valid = 1'b0;
        while (!wb_valid) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic illegal_check(input instr_t ins);
        issue(ins);
        assert (illegal && !wb_valid) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("error %0t: illegal=%b wb_valid=%b one cycle after bad opcode",
                     $time, illegal, wb_valid);
        end
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            assert (exp_rd_q.size() > 0) else begin
                fail_count++;
                $display("error %0t: writeback to x%0d with nothing outstanding", $time, wb_rd);
            end
            if (exp_rd_q.size() > 0) begin
                chk_rd   = exp_rd_q.pop_front();
                chk_data = exp_data_q.pop_front();
                assert (wb_rd == chk_rd && wb_data == chk_data) begin
                    pass_count++;
                end else begin
                    fail_count++;
                    $display("error %0t: writeback x%0d = %h, expected x%0d = %h",
                             $time, wb_rd, wb_data, chk_rd, chk_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        xlen_t a;
        xlen_t b;
        xlen_t r;
        seed        = 32'hb477597e;
        instr_valid = 1'b0;
        instr       = '0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        wait (rst_n);
        @(negedge clk);
        assert (!busy && !wb_valid && !illegal) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("error %0t: busy, wb_valid or illegal high after reset", $time);
        end
        reg_op(7'b0, 3'b000, 5'd3, 5'd1, 5'd2);

        for (int n = 0; n < ROUNDS; n++) begin
            load_reg(5'd1, $random(seed));
            load_reg(5'd2, $random(seed));
            for (int k = 0; k < 8; k++) begin
                reg_op(7'b0, 3'(k), reg_idx_t'(10 + k), 5'd1, 5'd2);
            end
            reg_op(7'b0100000, 3'b000, 5'd18, 5'd1, 5'd2);
            reg_op(7'b0100000, 3'b101, 5'd19, 5'd1, 5'd2);
            for (int k = 0; k < 8; k++) begin
                r = $random(seed);
                if (k != 1 && k != 5) begin
                    imm_op(3'(k), reg_idx_t'(10 + k), 5'd1, r[11:0]);
                end
            end
            r = $random(seed);
            imm_op(3'b001, 5'd11, 5'd1, {7'b0, r[4:0]});
            imm_op(3'b101, 5'd15, 5'd1, {7'b0, r[9:5]});
            imm_op(3'b101, 5'd16, 5'd2, {7'b0100000, r[14:10]});
            lui_op(5'd17, r[31:12]);
            alu_burst();
        end

        for (int n = 0; n < ROUNDS; n++) begin
            a = $random(seed);
            b = $random(seed);
            a[31] = a[31] | n[0];
            b[31] = b[31] | n[1];
            load_reg(5'd3, a);
            load_reg(5'd4, b);
            for (int k = 0; k < 4; k++) begin
                reg_op(FUNCT7_MULDIV, 3'(k), reg_idx_t'(20 + k), 5'd3, 5'd4);
            end
        end

        for (int n = 0; n < ROUNDS; n++) begin
            a = $random(seed);
            b = $random(seed);
            b = $signed(b) >>> (n * 9);
            if (b == '0) begin
                b = 32'd7;
            end
            if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                b = 32'd3;
            end
            load_reg(5'd5, a);
            load_reg(5'd6, b);
            for (int k = 4; k < 8; k++) begin
                reg_op(FUNCT7_MULDIV, 3'(k), reg_idx_t'(20 + k), 5'd5, 5'd6);
            end
        end

        imm_op(3'b000, 5'd0, 5'd1, 12'h05a);
        reg_op(7'b0, 3'b000, 5'd9, 5'd0, 5'd0);
        reg_op(7'b0, 3'b000, 5'd9, 5'd0, 5'd1);

        r = $random(seed);
        illegal_check({r[31:7], 7'b1101111});
        r = $random(seed);
        illegal_check({r[31:7], 7'b0000011});
        r = $random(seed);
        illegal_check({7'b0000010, r[24:7], OPC_OP});

        repeat (4) @(negedge clk);
        $display("Checks passed: %0d, failed: %0d, property failures: %0d",
                 pass_count, fail_count, rv_core_i.props_i.failures);
        if (fail_count == 0 && rv_core_i.props_i.failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_divider.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core.sv
tb/tb_clk_gen.sv
tb/rv_core_properties.sv
tb/tb_rv_core.sv
